// ==== rtl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // ==================================================
    // Basic types
    // ==================================================
    typedef logic [63:0] word_t;     // Registers, addresses and bus data
    typedef logic [3:0]  reg_idx_t;  // One of sixteen registers

    // Instruction classes
    typedef enum logic [3:0] {
        OP_R   = 4'h0,  // rd = rs1 op rs2
        OP_I   = 4'h1,  // Load from rs1 + imm
        OP_S   = 4'h2,  // Store rs2 at rs1 + imm
        OP_B   = 4'h3,  // Branch when rs1 == rs2
        OP_NOP = 4'hF   // Any other encoding
    } opcode_e;

    // ALU functions
    typedef enum logic [3:0] {
        ALU_ADD    = 4'h0,
        ALU_SUB    = 4'h1,
        ALU_MUL    = 4'h2,  // Low 64 bits only
        ALU_DIV    = 4'h3,  // Unsigned
        ALU_MOD    = 4'h4,  // Unsigned
        ALU_AND    = 4'h5,
        ALU_OR     = 4'h6,
        ALU_XOR    = 4'h7,
        ALU_SHL    = 4'h8,
        ALU_SHR    = 4'h9,  // Logical
        ALU_ROT    = 4'hA,  // Rotate left
        ALU_CMP    = 4'hB,  // Unsigned less-than
        ALU_CLZ    = 4'hC,
        ALU_CTZ    = 4'hD,
        ALU_POPCNT = 4'hE,
        ALU_NONE   = 4'hF   // Result is zero
    } alu_fn_e;

    // ==================================================
    // Instruction layout
    // ==================================================
    localparam int OPC_LSB = 60;  // Bits 63..60
    localparam int FN_LSB  = 56;  // Bits 59..56
    localparam int RS2_LSB = 52;  // Bits 55..52
    localparam int RS1_LSB = 48;  // Bits 51..48
    localparam int IMM_LSB = 32;  // Bits 47..32
    localparam int IMM_W   = 16;  // Signed immediate
    localparam int RD_LSB  = 0;   // Bits 3..0

    localparam word_t INSTR_BYTES = 64'd8;  // PC step

    // Counter readout select
    typedef enum logic [1:0] {
        PERF_CYCLES  = 2'd0,
        PERF_RETIRED = 2'd1,
        PERF_LOADS   = 2'd2,
        PERF_STORES  = 2'd3
    } perf_sel_e;

endpackage

`default_nettype wire

// ==== rtl/core_control.sv ====
`default_nettype none

module core_control import cpu_pkg::*; #(
    parameter word_t RESET_PC = 64'd4096
) (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        done,          // Bus request finished
    input  wire word_t rdata,
    input  wire opcode_e opcode,
    input  wire word_t rs1_data,
    input  wire word_t rs2_data,
    input  wire word_t imm_ext,
    output logic       req_fetch,
    output logic       req_load,
    output logic       req_store,
    output word_t      addr,
    output word_t      instr,
    output logic       rf_we,
    output logic       rf_wsel_mem,   // Write back loaded data
    output logic       retire,
    output logic       load_retire,
    output logic       store_retire,
    input  wire        debug_step,
    input  wire        debug_resume,
    output logic       debug_halt,
    output word_t      pc
);

    typedef enum logic [2:0] {S_IDLE, S_FETCH, S_EXEC, S_MEM, S_LWB} state_e;

    state_e state;
    logic   started;     // First cycle out of reset has passed
    logic   stop_req;    // Halt at the next boundary
    logic   is_mem;
    logic   exec_flow;   // R, B or no-op finishing in execute
    logic   store_done;
    logic   br_taken;
    word_t  eff_addr;
    word_t  seq_pc;
    word_t  br_target;
    word_t  next_pc;
    word_t  ir;

    // ==================================================
    // Decisions for the current state
    // ==================================================
    assign is_mem     = (opcode == OP_I) || (opcode == OP_S);
    assign exec_flow  = (state == S_EXEC) && !is_mem;
    assign store_done = (state == S_MEM) && done && (opcode == OP_S);

    assign eff_addr  = rs1_data + imm_ext;                          // Load/store address
    assign seq_pc    = pc + INSTR_BYTES;
    assign br_target = pc + (imm_ext << $clog2(INSTR_BYTES));       // Offset in instructions
    assign br_taken  = exec_flow && (opcode == OP_B) && (rs1_data == rs2_data);
    assign next_pc   = br_taken ? br_target : seq_pc;

    assign retire       = exec_flow || (state == S_LWB) || store_done;
    assign load_retire  = (state == S_LWB);
    assign store_retire = store_done;

    // Chain the next fetch straight after retire unless a halt is due
    assign req_fetch = ((exec_flow || (state == S_LWB)) && !stop_req)
                     || ((state == S_IDLE) && started && !debug_halt);
    assign req_load  = (state == S_EXEC) && (opcode == OP_I);
    assign req_store = (state == S_EXEC) && (opcode == OP_S);

    always_comb begin
        if ((state == S_EXEC) && is_mem) begin
            addr = eff_addr;
        end else if (state == S_IDLE) begin
            addr = pc;       // Restart after halt or store
        end else begin
            addr = next_pc;  // Fetch chained to retire
        end
    end

    assign rf_we       = (exec_flow && (opcode == OP_R)) || (state == S_LWB);
    assign rf_wsel_mem = (state == S_LWB);
    assign instr       = ir;

    // ==================================================
    // Sequencer
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            pc      <= RESET_PC;
            started <= 1'b0;
        end else begin
            started <= 1'b1;
            if (retire) begin
                pc <= next_pc;
            end
            case (state)
                S_IDLE:  if (req_fetch) state <= S_FETCH;
                S_FETCH: if (done) state <= S_EXEC;
                S_EXEC: begin
                    if (is_mem) begin
                        state <= S_MEM;
                    end else begin
                        state <= req_fetch ? S_FETCH : S_IDLE;
                    end
                end
                S_MEM:   if (done) state <= (opcode == OP_S) ? S_IDLE : S_LWB;
                S_LWB:   state <= req_fetch ? S_FETCH : S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == S_FETCH) && done) begin
            ir <= rdata;  // Instruction word
        end
    end

    // Halt and single step
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            debug_halt <= 1'b0;
            stop_req   <= 1'b0;
        end else if (debug_resume) begin
            debug_halt <= 1'b0;
            stop_req   <= 1'b0;
        end else if (debug_step) begin
            debug_halt <= 1'b0;  // Releases one instruction when halted
            stop_req   <= 1'b1;
        end else if (retire && stop_req) begin
            debug_halt <= 1'b1;
            stop_req   <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/inst_decode.sv ====
`default_nettype none

module inst_decode import cpu_pkg::*; (
    input  wire word_t instr,
    output opcode_e    opcode,
    output alu_fn_e    funct,
    output reg_idx_t   rs1,
    output reg_idx_t   rs2,
    output reg_idx_t   rd,
    output word_t      imm_ext
);

    logic [3:0]       opc_raw;
    logic [IMM_W-1:0] imm_raw;

    assign opc_raw = instr[OPC_LSB +: 4];
    assign imm_raw = instr[IMM_LSB +: IMM_W];

    // ==================================================
    // Instruction class
    // ==================================================
    always_comb begin
        case (opc_raw)
            OP_R, OP_I, OP_S, OP_B: opcode = opcode_e'(opc_raw);
            default:                opcode = OP_NOP;  // Unsupported classes
        endcase
    end

    // Register fields
    assign funct = alu_fn_e'(instr[FN_LSB +: 4]);
    assign rs1   = instr[RS1_LSB +: $bits(reg_idx_t)];
    assign rs2   = instr[RS2_LSB +: $bits(reg_idx_t)];
    assign rd    = instr[RD_LSB +: $bits(reg_idx_t)];

    // Sign extend to a full word
    assign imm_ext = {{($bits(word_t) - IMM_W){imm_raw[IMM_W-1]}}, imm_raw};

endmodule

`default_nettype wire

// ==== rtl/int_alu.sv ====
`default_nettype none

module int_alu import cpu_pkg::*; (
    input  wire word_t   a,
    input  wire word_t   b,
    input  wire alu_fn_e funct,
    output word_t        result
);

    logic [5:0] sh;      // Shift amount from b
    logic [6:0] clz;
    logic [6:0] ctz;
    word_t      rot;

    assign sh = b[5:0];

    // Left rotate, zero amount passes a through
    assign rot = (sh == 6'd0) ? a : ((a << sh) | (a >> (7'd64 - {1'b0, sh})));

    // ==================================================
    // Bit counts
    // ==================================================
    always_comb begin
        clz = 7'd64;                  // Zero input
        for (int i = 0; i < 64; i++) begin
            if (a[i]) begin
                clz = 7'(63 - i);     // Highest set bit wins
            end
        end
    end

    always_comb begin
        ctz = 7'd64;                  // Zero input
        for (int i = 63; i >= 0; i--) begin
            if (a[i]) begin
                ctz = 7'(i);          // Lowest set bit wins
            end
        end
    end

    // ==================================================
    // Function select
    // ==================================================
    always_comb begin
        case (funct)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_MUL:    result = a * b;                      // Low half
            ALU_DIV:    result = (b == '0) ? '0 : a / b;
            ALU_MOD:    result = (b == '0) ? '0 : a % b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_SHL:    result = a << sh;
            ALU_SHR:    result = a >> sh;
            ALU_ROT:    result = rot;
            ALU_CMP:    result = {63'd0, (a < b)};           // Unsigned
            ALU_CLZ:    result = {57'd0, clz};
            ALU_CTZ:    result = {57'd0, ctz};
            ALU_POPCNT: result = word_t'($countones(a));
            default:    result = '0;                         // Function 15
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  wire           clk,
    input  wire           rst_n,
    input  wire reg_idx_t rs1,
    input  wire reg_idx_t rs2,
    input  wire reg_idx_t rd,
    input  wire reg_idx_t dbg_sel,
    input  wire           we,
    input  wire word_t    wdata,
    output word_t         rs1_data,
    output word_t         rs2_data,
    output word_t         dbg_data
);

    word_t regs [16];

    // Single write port
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[rd] <= wdata;
        end
    end

    // Combinational reads
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];
    assign dbg_data = regs[dbg_sel];  // Debug readout

endmodule

`default_nettype wire

// ==== rtl/mem_port.sv ====
`default_nettype none

module mem_port import cpu_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        req_fetch,
    input  wire        req_load,
    input  wire        req_store,
    input  wire word_t addr,
    input  wire word_t wdata,
    output logic       done,
    output word_t      rdata,
    output word_t      mem_addr,
    output word_t      mem_wdata,
    output logic       mem_re,
    output logic       mem_we,
    input  wire word_t mem_rdata,
    input  wire        mem_ready
);

    logic busy;
    logic req_any;

    assign busy    = mem_re || mem_we;
    assign req_any = req_fetch || req_load || req_store;

    // ==================================================
    // Strobes and completion
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_re <= 1'b0;
            mem_we <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;                    // One-cycle pulse
            if (busy) begin
                if (mem_ready) begin         // Edge that completes the request
                    mem_re <= 1'b0;
                    mem_we <= 1'b0;
                    done   <= 1'b1;
                end
            end else begin
                mem_re <= req_fetch || req_load;
                mem_we <= req_store;
            end
        end
    end

    // Address and data held for the whole request
    always_ff @(posedge clk) begin
        if (!busy && req_any) begin
            mem_addr  <= addr;
            mem_wdata <= wdata;
        end
        if (mem_re && mem_ready) begin
            rdata <= mem_rdata;              // Stays until the next read
        end
    end

endmodule

`default_nettype wire

// ==== rtl/perf_counters.sv ====
`default_nettype none

module perf_counters import cpu_pkg::*; #(
    parameter int CTR_WIDTH = 32
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  retire,
    input  wire                  load_retire,
    input  wire                  store_retire,
    input  wire perf_sel_e       sel,
    output logic [CTR_WIDTH-1:0] data
);

    logic [CTR_WIDTH-1:0] cycles;
    logic [CTR_WIDTH-1:0] retired;
    logic [CTR_WIDTH-1:0] loads;
    logic [CTR_WIDTH-1:0] stores;

    // All four wrap at full width
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycles  <= '0;
            retired <= '0;
            loads   <= '0;
            stores  <= '0;
        end else begin
            cycles <= cycles + 1'b1;  // Runs while halted too
            if (retire)       retired <= retired + 1'b1;
            if (load_retire)  loads   <= loads + 1'b1;
            if (store_retire) stores  <= stores + 1'b1;
        end
    end

    // Readout mux
    always_comb begin
        case (sel)
            PERF_CYCLES:  data = cycles;
            PERF_RETIRED: data = retired;
            PERF_LOADS:   data = loads;
            default:      data = stores;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/cpu_core.sv ====
`default_nettype none

module cpu_core import cpu_pkg::*; #(
    parameter word_t RESET_PC  = 64'd4096,
    parameter int    CTR_WIDTH = 32
) (
    input  wire                  clk,
    input  wire                  rst_n,
    output word_t                mem_addr,
    output word_t                mem_wdata,
    output logic                 mem_we,
    output logic                 mem_re,
    input  wire word_t           mem_rdata,
    input  wire                  mem_ready,
    input  wire                  debug_step,
    input  wire                  debug_resume,
    output logic                 debug_halt,
    output word_t                debug_pc,
    input  wire reg_idx_t        debug_reg_sel,
    output word_t                debug_reg_data,
    input  wire perf_sel_e       perf_sel,
    output logic [CTR_WIDTH-1:0] perf_data
);

    // ==================================================
    // Internal wires
    // ==================================================
    logic     req_fetch, req_load, req_store, done;
    logic     rf_we, rf_wsel_mem;
    logic     retire, load_retire, store_retire;
    word_t    req_addr, bus_rdata, instr;
    word_t    rs1_data, rs2_data, imm_ext, alu_result, rf_wdata;
    opcode_e  opcode;
    alu_fn_e  funct;
    reg_idx_t rs1, rs2, rd;

    // Write-back source
    assign rf_wdata = rf_wsel_mem ? bus_rdata : alu_result;

    core_control #(.RESET_PC(RESET_PC)) u_ctrl (
        .clk, .rst_n, .done, .rdata(bus_rdata), .opcode, .rs1_data, .rs2_data, .imm_ext,
        .req_fetch, .req_load, .req_store, .addr(req_addr), .instr, .rf_we, .rf_wsel_mem,
        .retire, .load_retire, .store_retire, .debug_step, .debug_resume, .debug_halt,
        .pc(debug_pc)
    );

    inst_decode u_dec (.instr, .opcode, .funct, .rs1, .rs2, .rd, .imm_ext);

    int_alu u_alu (.a(rs1_data), .b(rs2_data), .funct, .result(alu_result));

    reg_file u_rf (
        .clk, .rst_n, .rs1, .rs2, .rd, .dbg_sel(debug_reg_sel), .we(rf_we),
        .wdata(rf_wdata), .rs1_data, .rs2_data, .dbg_data(debug_reg_data)
    );

    mem_port u_mem (
        .clk, .rst_n, .req_fetch, .req_load, .req_store, .addr(req_addr),
        .wdata(rs2_data), .done, .rdata(bus_rdata), .mem_addr, .mem_wdata,
        .mem_re, .mem_we, .mem_rdata, .mem_ready
    );

    perf_counters #(.CTR_WIDTH(CTR_WIDTH)) u_perf (
        .clk, .rst_n, .retire, .load_retire, .store_retire, .sel(perf_sel),
        .data(perf_data)
    );

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 4
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD / 2) clk = ~clk;  // Free running, 50% duty

endmodule

`default_nettype wire

// ==== test/cpu_core_assertions.sv ====
`default_nettype none

module cpu_core_assertions import cpu_pkg::*; #(
    parameter word_t RESET_PC = 64'd4096
) (
    input wire        clk,
    input wire        rst_n,
    input wire        mem_re,
    input wire        mem_we,
    input wire        mem_ready,
    input wire word_t mem_addr,
    input wire word_t mem_wdata,
    input wire        debug_halt
);

    logic seen_req;        // Some request already issued since reset
    int   fail_count = 0;  // Failed assertions so far

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_req <= 1'b0;
        end else if (mem_re || mem_we) begin
            seen_req <= 1'b1;
        end
    end

    // ==================================================
    // Reset behavior
    // ==================================================
    a_reset_quiet: assert property (@(posedge clk)
        (!rst_n || !$past(rst_n)) |-> (!mem_re && !mem_we && !debug_halt))
        else begin
            fail_count++;
            $error("bus strobe or halt active around reset");
        end

    a_first_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        ((mem_re || mem_we) && !seen_req) |-> (mem_re && mem_addr == RESET_PC))
        else begin
            fail_count++;
            $error("first request after reset is not a read at the reset address");
        end

    // ==================================================
    // Bus protocol
    // ==================================================
    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_re && mem_we))
        else begin
            fail_count++;
            $error("read and write strobes high together");
        end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ((mem_re || mem_we) && !mem_ready) |=>
            ($stable(mem_addr) && $stable(mem_wdata) && $stable(mem_re) && $stable(mem_we)))
        else begin
            fail_count++;
            $error("request changed before mem_ready");
        end

    a_gap: assert property (@(posedge clk) disable iff (!rst_n)
        ((mem_re || mem_we) && mem_ready) |=> (!mem_re && !mem_we))
        else begin
            fail_count++;
            $error("strobe still high in the cycle after completion");
        end

endmodule

`default_nettype wire

// ==== test/cpu_core_tb.sv ====
`default_nettype none

module cpu_core_tb import cpu_pkg::*; ();

    localparam word_t RESET_PC  = 64'd4096;
    localparam int    CTR_WIDTH = 32;
    localparam word_t DATA_BASE = 64'h2000;   // Random operands
    localparam int    OUT_BASE  = 'h3000;     // Stored results
    localparam int    WATCHDOG  = 400 * 16 * 4;

    logic clk, rst_n, mem_we, mem_re, mem_ready, debug_step, debug_resume, debug_halt;
    word_t mem_addr, mem_wdata, mem_rdata, debug_pc, debug_reg_data;
    reg_idx_t debug_reg_sel;
    perf_sel_e perf_sel;
    logic [CTR_WIDTH-1:0] perf_data;

    word_t mem [word_t];                      // Sparse memory
    word_t ref_regs [16];
    word_t ref_pc, loop_addr, prog_end, exp_addr, exp_data;
    reg_idx_t load_rd;
    int pending;                              // 0 fetch, 1 load, 2 store
    int ref_retired, ref_loads, ref_stores, fetch_count, loop_hits;
    int value_errs, other_errs, wait_left;
    bit active;

    tb_clock_gen #(.PERIOD(4)) clk_i (.clk(clk));

    cpu_core #(.RESET_PC(RESET_PC), .CTR_WIDTH(CTR_WIDTH)) dut_i (
        .clk, .rst_n, .mem_addr, .mem_wdata, .mem_we, .mem_re, .mem_rdata, .mem_ready,
        .debug_step, .debug_resume, .debug_halt, .debug_pc, .debug_reg_sel,
        .debug_reg_data, .perf_sel, .perf_data
    );

    bind cpu_core cpu_core_assertions #(.RESET_PC(RESET_PC)) asrt_i (
        .clk(clk), .rst_n(rst_n), .mem_re(mem_re), .mem_we(mem_we), .mem_ready(mem_ready),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .debug_halt(debug_halt)
    );

    // ==================================================
    // Helpers
    // ==================================================
    function automatic word_t enc(input logic [3:0] op, input logic [3:0] fn,
                                  input logic [3:0] rs2, input logic [3:0] rs1,
                                  input logic [15:0] imm, input logic [3:0] rd);
        return {op, fn, rs2, rs1, imm, 28'd0, rd};
    endfunction

    function automatic word_t read_mem(input word_t a);
        return mem.exists(a) ? mem[a] : '0;   // Unwritten reads as zero
    endfunction

    // Expected ALU result per function
    function automatic word_t alu_ref(input logic [3:0] fn, input word_t a, input word_t b);
        word_t r;
        int    n;
        r = '0;
        n = 0;
        case (fn)
            4'd0:  r = a + b;
            4'd1:  r = a - b;
            4'd2:  r = a * b;
            4'd3:  if (b != 0) r = a / b;
            4'd4:  if (b != 0) r = a % b;
            4'd5:  r = a & b;
            4'd6:  r = a | b;
            4'd7:  r = a ^ b;
            4'd8:  r = a << b[5:0];
            4'd9:  r = a >> b[5:0];
            4'd10: begin
                r = a;
                repeat (b[5:0]) r = {r[62:0], r[63]};  // One bit at a time
            end
            4'd11: r = (a < b) ? 64'd1 : 64'd0;
            4'd12: begin
                while (n < 64 && !a[63 - n]) n++;
                r = word_t'(n);
            end
            4'd13: begin
                while (n < 64 && !a[n]) n++;
                r = word_t'(n);
            end
            4'd14: begin
                for (int i = 0; i < 64; i++) n += int'(a[i]);
                r = word_t'(n);
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic check_value(input string name, input word_t exp, input word_t act);
        assert (exp == act) else begin
            value_errs++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic report_failure(input string what);
        other_errs++;
        $display("failure: %s", what);
    endtask

    task automatic emit(input word_t ins);
        mem[prog_end] = ins;
        prog_end += INSTR_BYTES;
    endtask

    task automatic alu_and_store(input int fn, input int rs1, input int rs2, input int slot);
        emit(enc(OP_R, 4'(fn), 4'(rs2), 4'(rs1), 16'd0, 4'd5));
        emit(enc(OP_S, 4'd0, 4'd5, 4'd0, 16'(OUT_BASE + slot * 8), 4'd0));
    endtask

    task automatic build_program();
        mem[DATA_BASE]     = {$urandom, $urandom};
        mem[DATA_BASE + 8] = {$urandom, $urandom};
        if (mem[DATA_BASE] == mem[DATA_BASE + 8]) mem[DATA_BASE + 8] ^= 64'd1;  // Keep r1 != r2
        prog_end = RESET_PC;
        emit(enc(OP_I, 4'd0, 4'd0, 4'd0, 16'h2000, 4'd1));
        emit(enc(OP_I, 4'd0, 4'd0, 4'd0, 16'h2008, 4'd2));
        for (int fn = 0; fn < 16; fn++) alu_and_store(fn, 1, 2, fn);
        alu_and_store(3, 1, 0, 16);                              // Divide by zero
        alu_and_store(4, 1, 0, 17);
        alu_and_store(12, 0, 2, 18);                             // Zero input counts
        alu_and_store(13, 0, 2, 19);
        emit(enc(4'h7, 4'd0, 4'd0, 4'd0, 16'd0, 4'd0));          // No-op class
        emit(enc(OP_B, 4'd0, 4'd2, 4'd1, 16'd5, 4'd0));          // Not taken
        emit(enc(OP_B, 4'd0, 4'd0, 4'd0, 16'd2, 4'd0));          // Taken branch skips the store
        emit(enc(OP_S, 4'd0, 4'd1, 4'd0, 16'h30F0, 4'd0));
        loop_addr = prog_end;
        emit(enc(OP_B, 4'd0, 4'd0, 4'd0, 16'd0, 4'd0));          // Self loop
    endtask

    // Reference model steps one instruction per fetch
    task automatic execute_ref(input word_t ins);
        logic [3:0] op;
        reg_idx_t   s1, s2, d;
        word_t      imm;
        op  = ins[63:60];
        s2  = ins[55:52];
        s1  = ins[51:48];
        d   = ins[3:0];
        imm = {{48{ins[47]}}, ins[47:32]};
        case (op)
            4'd0: ref_regs[d] = alu_ref(ins[59:56], ref_regs[s1], ref_regs[s2]);
            4'd1: begin
                exp_addr = ref_regs[s1] + imm;
                load_rd  = d;
                pending  = 1;
            end
            4'd2: begin
                exp_addr = ref_regs[s1] + imm;
                exp_data = ref_regs[s2];
                pending  = 2;
            end
            default: ;
        endcase
        if (op != 4'd1 && op != 4'd2) ref_retired++;       // Others retire on completion
        if (op == 4'd3 && ref_regs[s1] == ref_regs[s2]) ref_pc = ref_pc + (imm << 3);
        else ref_pc = ref_pc + INSTR_BYTES;
    endtask

    task automatic serve_request();
        if (pending == 0) begin
            assert (mem_re) else report_failure("write request where a fetch was expected");
            check_value("fetch address", ref_pc, mem_addr);
            mem_rdata = read_mem(mem_addr);
            fetch_count++;
            if (mem_addr == loop_addr) loop_hits++;
            execute_ref(read_mem(ref_pc));
        end else if (pending == 1) begin
            assert (mem_re) else report_failure("write request where a load was expected");
            check_value("load address", exp_addr, mem_addr);
            mem_rdata = read_mem(mem_addr);
            ref_regs[load_rd] = read_mem(exp_addr);
            ref_loads++;
            ref_retired++;
            pending = 0;
        end else begin
            assert (mem_we) else report_failure("read request where a store was expected");
            check_value("store address", exp_addr, mem_addr);
            check_value("store data", exp_data, mem_wdata);
            mem[mem_addr] = mem_wdata;
            ref_stores++;
            ref_retired++;
            pending = 0;
        end
    endtask

    task automatic wait_for_halt(output bit ok);
        ok = 1'b0;
        repeat (100) begin
            @(posedge clk);
            #2;
            if (debug_halt) begin
                ok = 1'b1;
                break;
            end
        end
    endtask

    task automatic pulse(ref logic sig);
        @(posedge clk);
        #1 sig = 1'b1;
        @(posedge clk);
        #1 sig = 1'b0;
    endtask

    // ==================================================
    // Memory model with 0 to 3 wait cycles per request
    // ==================================================
    always @(posedge clk) begin
        #1;
        if (!(mem_re || mem_we)) begin
            active    = 1'b0;
            mem_ready = 1'b0;
        end else if (!mem_ready) begin
            if (!active) begin
                active    = 1'b1;
                wait_left = int'($urandom % 4);
            end
            if (wait_left == 0) begin
                mem_ready = 1'b1;
                serve_request();
            end else begin
                wait_left--;
            end
        end
    end

    initial begin
        #(WATCHDOG);
        $display("timeout: run did not finish within %0d time units", WATCHDOG);
        $display("** FAIL **");
        $finish;
    end

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        int k;
        bit ok;
        logic [CTR_WIDTH-1:0] c0;
        void'($urandom(32'h8c3a));
        {rst_n, mem_ready, debug_step, debug_resume} = '0;
        mem_rdata = '0;
        debug_reg_sel = '0;
        perf_sel = PERF_CYCLES;
        foreach (ref_regs[i]) ref_regs[i] = '0;
        {pending, ref_retired, ref_loads, ref_stores, fetch_count, loop_hits} = '0;
        {value_errs, other_errs, wait_left} = '0;
        active = 1'b0;
        ref_pc = RESET_PC;
        build_program();
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;

        while (loop_hits < 3) @(posedge clk);   // Wait for the final self loop
        pulse(debug_step);
        wait_for_halt(ok);
        assert (ok) else report_failure("core did not halt after a step while running");
        repeat (10) begin
            @(posedge clk);
            #2;
            assert (!(mem_re || mem_we)) else report_failure("bus request while halted");
        end
        check_value("debug pc", loop_addr, debug_pc);
        for (int r = 0; r < 16; r++) begin
            @(posedge clk);
            #1 debug_reg_sel = reg_idx_t'(r);
            #1 check_value($sformatf("register r%0d", r), ref_regs[r], debug_reg_data);
        end

        // Counters
        @(posedge clk);
        #1 perf_sel = PERF_RETIRED;
        #1 check_value("retired count", word_t'(ref_retired), word_t'(perf_data));
        @(posedge clk);
        #1 perf_sel = PERF_LOADS;
        #1 check_value("load count", word_t'(ref_loads), word_t'(perf_data));
        @(posedge clk);
        #1 perf_sel = PERF_STORES;
        #1 check_value("store count", word_t'(ref_stores), word_t'(perf_data));
        @(posedge clk);
        #1 perf_sel = PERF_CYCLES;
        #1 c0 = perf_data;
        repeat (2) @(posedge clk);
        #2;
        assert (perf_data - c0 >= 2) else report_failure("cycle counter advanced too little");

        // One step from halt
        k = fetch_count;
        pulse(debug_step);
        wait_for_halt(ok);
        assert (ok) else report_failure("core did not halt again after a single step");
        repeat (4) @(posedge clk);
        #2;
        check_value("fetches per step", word_t'(k + 1), word_t'(fetch_count));
        check_value("debug pc after step", loop_addr, debug_pc);

        k = fetch_count;
        pulse(debug_resume);
        for (int n = 0; n < 20 && fetch_count == k; n++) @(posedge clk);
        #2;
        assert (fetch_count > k && !debug_halt) else report_failure("no fetch after resume");

        $display("value errors: %0d, other errors: %0d, assertion errors: %0d",
                 value_errs, other_errs, dut_i.asrt_i.fail_count);
        if (value_errs + other_errs + dut_i.asrt_i.fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
rtl/cpu_pkg.sv
rtl/core_control.sv
rtl/inst_decode.sv
rtl/int_alu.sv
rtl/reg_file.sv
rtl/mem_port.sv
rtl/perf_counters.sv
rtl/cpu_core.sv
test/tb_clock_gen.sv
test/cpu_core_assertions.sv
test/cpu_core_tb.sv

// ==== Makefile ====
# Verilator simulation of the multicycle core

VERILATOR ?= verilator
TOP       ?= cpu_core_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, pass if the log shows the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
